/* bench/testdata.txt */
// Hex words for $readmemh, each @ line sets the word address of the words after it
// @100 data words, @200 program at RESET_PC/4, @300 length, store count, then address data pairs
@100
a5c30f96
@200
// Setup and first store
123450b7 67808093 00102023 87654137 32110113 70400193
// Register forms, each followed by its store
00310233 00402223 40310233 00402423 00311233 00402623 00315233 00402823
40315233 00402a23 00312233 00402c23 00313233 00402e23 00314233 02402023
00316233 02402223 00317233 02402423
// Immediate forms
fff10213 02402623 00512213 02402823 00513213 02402a23 0f014213 02402c23
0f016213 02402e23 0f017213 04402023 00811213 04402223 00815213 04402423
40815213 04402623
// Branches, each over one marker store
00318463 10102023 00310463 10102223 00311463 10102423 00319463 10102623
00314463 10102823 0021c463 10102a23 0021d463 10102c23 00315463 10102e23
0021e463 12102023 00316463 12102223 00317463 12102423 0021f463 12102623
// JAL, AUIPC, JALR, AUIPC, LW, LUI, then spin on JAL
00c002ef 12102823 12102823 12502a23 00000317 011303e7 12102823 12102823
12702c23 12602e23 12345417 14802023 40002483 14902223 fedcb537 14a02423
0000006f
@300
00000055 00000020
// LUI and ADDI, then register forms
00000000 12345678 00000004 87654a25
00000008 87653c1d 0000000c 76543210
00000010 08765432 00000014 f8765432
00000018 00000001 0000001c 00000000
00000020 87654425 00000024 87654725
// AND, then immediate forms
00000028 00000300 0000002c 87654320
00000030 00000001 00000034 00000000
00000038 876543d1 0000003c 876543f1
00000040 00000020 00000044 65432100
00000048 00876543 0000004c ff876543
// Markers of the not-taken branches
00000104 12345678 0000010c 12345678
00000114 12345678 0000011c 12345678
00000124 12345678 0000012c 12345678
// JAL link, JALR link, AUIPC twice, LW copy, LUI
00000134 00000914 00000138 00000928
0000013c 00000920 00000140 12345938
00000144 a5c30f96 00000148 fedcb000

/* project.f */
design/rv_pkg.sv
design/program_counter.sv
design/reg_file.sv
design/instr_decoder.sv
design/alu.sv
design/core_control.sv
design/rv_core.sv
bench/core_tb.sv

/* run.sh */
#!/bin/sh
# Builds the core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module core_tb \
        -f project.f -o core_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$log" 2>&1
run_status=$?
cat "$log"

if [ "$run_status" -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "sim failed" "$log"; then
    echo "Testbench reported a failure"
    exit 1
fi

exit 0

/* bench/core_tb.sv */
module core_tb;
    import rv_pkg::*;

    localparam xlen_t      RESET_PC   = 32'd2048;
    localparam int         CLK_PERIOD = 100;
    localparam int         MEM_WORDS  = 1024;
    // Word address of program length, store count and the store table
    localparam logic [9:0] TABLE_BASE = 10'h300;

    logic     clk;
    logic     rst;
    xlen_t    instr_addr;
    xlen_t    instr;
    mem_req_t mem_req;
    xlen_t    mem_rdata;

    xlen_t image [0:MEM_WORDS-1];
    xlen_t imem  [0:MEM_WORDS-1];
    xlen_t dmem  [0:MEM_WORDS-1];

    int prog_len;
    int store_total;
    int store_seen;
    bit loaded;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .instr_addr(instr_addr),
        .instr     (instr),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Both memories answer combinationally, 4 KB each
    assign instr     = imem[instr_addr[11:2]];
    assign mem_rdata = dmem[mem_req.addr[11:2]];

    always @(posedge clk) begin
        if (mem_req.write) begin
            dmem[mem_req.addr[11:2]] <= mem_req.wdata;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: expected %08h, actual %08h",
                                name, expected, actual));
        end
    endtask

    task automatic check_store(input xlen_t addr, input xlen_t data);
        logic [9:0] row;
        if (store_seen >= store_total) begin
            abort_run($sformatf("Unexpected store of %08h to %08h after the last expected one",
                                data, addr));
        end else begin
            row = TABLE_BASE + 10'd2 + 10'(2 * store_seen);
            check_value($sformatf("store %0d address", store_seen), image[row], addr);
            check_value($sformatf("store %0d data", store_seen), image[row + 10'd1], data);
            store_seen++;
        end
    endtask

    // mem_req is registered, so mid-cycle is a safe sampling point
    always @(negedge clk) begin
        if (!rst && mem_req.write) begin
            check_store(mem_req.addr, mem_req.wdata);
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        store_seen = 0;
        $readmemh("bench/testdata.txt", image);
        imem        = image;
        dmem        = image;
        prog_len    = int'(image[TABLE_BASE]);
        store_total = int'(image[TABLE_BASE + 10'd1]);
        loaded      = 1'b1;

        repeat (5) @(negedge clk);
        rst = 1'b0;

        // First IF state follows the first rising edge out of reset
        @(posedge clk);
        @(negedge clk);
        check_value("reset fetch address", RESET_PC, instr_addr);

        wait (store_seen == store_total);
        // Two more instruction periods to catch a stray store
        repeat (12) @(posedge clk);
        $display("sim passed");
        $finish;
    end

    // Four times the nominal runtime of the whole program image
    initial begin
        wait (loaded);
        if (store_total == 0) begin
            abort_run("The data file lists no expected stores");
        end else begin
            #(prog_len * 6 * CLK_PERIOD * 4);
            abort_run($sformatf("Timeout: only %0d of %0d expected stores arrived",
                                store_seen, store_total));
        end
    end

endmodule

/* design/rv_core.sv */
module rv_core #(
    parameter rv_pkg::xlen_t RESET_PC = 32'd2048
) (
    input  logic             clk,
    input  logic             rst,
    output rv_pkg::xlen_t    instr_addr,
    input  rv_pkg::xlen_t    instr,
    output rv_pkg::mem_req_t mem_req,
    input  rv_pkg::xlen_t    mem_rdata
);
    import rv_pkg::*;

    xlen_t    pc_next;
    pc_mode_t pc_mode;
    xlen_t    pc_offset;
    xlen_t    pc_target;
    reg_idx_t raddr0;
    reg_idx_t raddr1;
    reg_idx_t waddr;
    logic     wen;
    xlen_t    wdata;
    xlen_t    rdata0;
    xlen_t    rdata1;
    alu_op_t  alu_op;
    xlen_t    alu_a;
    xlen_t    alu_b;
    xlen_t    alu_result;
    xlen_t    instr_q;
    decoded_t dec;

    program_counter #(
        .RESET_PC(RESET_PC)
    ) pc_i (
        .clk    (clk),
        .rst    (rst),
        .mode   (pc_mode),
        .offset (pc_offset),
        .target (pc_target),
        .pc     (instr_addr),
        .pc_next(pc_next)
    );

    reg_file rf_i (
        .clk   (clk),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata),
        .raddr0(raddr0),
        .raddr1(raddr1),
        .rdata0(rdata0),
        .rdata1(rdata1)
    );

    // Decodes the latched word, not the live fetch bus
    instr_decoder dec_i (
        .instr(instr_q),
        .dec  (dec)
    );

    alu alu_i (
        .op    (alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .result(alu_result)
    );

    core_control ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .instr_q   (instr_q),
        .dec       (dec),
        .pc        (instr_addr),
        .pc_next   (pc_next),
        .rdata0    (rdata0),
        .rdata1    (rdata1),
        .alu_result(alu_result),
        .mem_rdata (mem_rdata),
        .pc_mode   (pc_mode),
        .pc_offset (pc_offset),
        .pc_target (pc_target),
        .raddr0    (raddr0),
        .raddr1    (raddr1),
        .waddr     (waddr),
        .wen       (wen),
        .wdata     (wdata),
        .alu_op    (alu_op),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .mem_req   (mem_req)
    );

endmodule

/* design/core_control.sv */
module core_control (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::xlen_t    instr,
    output rv_pkg::xlen_t    instr_q,
    input  rv_pkg::decoded_t dec,
    input  rv_pkg::xlen_t    pc,
    input  rv_pkg::xlen_t    pc_next,
    input  rv_pkg::xlen_t    rdata0,
    input  rv_pkg::xlen_t    rdata1,
    input  rv_pkg::xlen_t    alu_result,
    input  rv_pkg::xlen_t    mem_rdata,
    output rv_pkg::pc_mode_t pc_mode,
    output rv_pkg::xlen_t    pc_offset,
    output rv_pkg::xlen_t    pc_target,
    output rv_pkg::reg_idx_t raddr0,
    output rv_pkg::reg_idx_t raddr1,
    output rv_pkg::reg_idx_t waddr,
    output logic             wen,
    output rv_pkg::xlen_t    wdata,
    output rv_pkg::alu_op_t  alu_op,
    output rv_pkg::xlen_t    alu_a,
    output rv_pkg::xlen_t    alu_b,
    output rv_pkg::mem_req_t mem_req
);
    import rv_pkg::*;

    core_state_t state;
    logic        mem_write;
    xlen_t       mem_addr;
    xlen_t       mem_wdata;

    function automatic alu_op_t funct3_op(logic [2:0] f3, logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    function automatic alu_op_t alu_sel(decoded_t d);
        case (d.op)
            OPC_OP:     return funct3_op(d.funct3, d.funct7_5);
            // Bit 30 is immediate data except on SRAI
            OPC_OP_IMM: return funct3_op(d.funct3, d.funct7_5 && d.funct3 == F3_SR);
            OPC_BRANCH: begin
                case (d.funct3)
                    F3_BLT, F3_BGE:   return ALU_SLT;
                    F3_BLTU, F3_BGEU: return ALU_SLTU;
                    default:          return ALU_SUB;
                endcase
            end
            // Address and link arithmetic
            default:    return ALU_ADD;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, xlen_t res);
        case (f3)
            F3_BEQ:           return res == 32'd0;
            F3_BNE:           return res != 32'd0;
            F3_BLT, F3_BLTU:  return res[0];
            F3_BGE, F3_BGEU:  return !res[0];
            default:          return 1'b0;
        endcase
    endfunction

    function automatic pc_mode_t next_mode(decoded_t d, xlen_t res);
        case (d.op)
            OPC_BRANCH:        return branch_taken(d.funct3, res) ? PC_BRANCH : PC_NEXT;
            OPC_JAL, OPC_JALR: return PC_JUMP;
            default:           return PC_NEXT;
        endcase
    endfunction

    function automatic xlen_t wb_sel(opcode_t op, xlen_t res, xlen_t imm, xlen_t link,
                                     xlen_t load);
        case (op)
            OPC_LUI:           return imm;
            OPC_JAL, OPC_JALR: return link;
            OPC_LOAD:          return load;
            default:           return res;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_HALT;
            pc_mode   <= PC_HOLD;
            wen       <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            case (state)
                ST_HALT: begin
                    state   <= ST_IF;
                    pc_mode <= PC_JUMP;
                end
                ST_IF: state <= ST_ID;
                ST_ID: state <= ST_EX;
                ST_EX: state <= ST_MM;
                ST_MM: begin
                    state     <= ST_WB;
                    wen       <= dec.op inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                                OPC_JAL, OPC_JALR, OPC_LOAD};
                    mem_write <= (dec.op == OPC_STORE);
                end
                ST_WB: begin
                    state     <= ST_X1;
                    pc_mode   <= next_mode(dec, alu_result);
                    // Store strobe covers WB only
                    mem_write <= 1'b0;
                end
                ST_X1: begin
                    state   <= ST_IF;
                    wen     <= 1'b0;
                    pc_mode <= PC_HOLD;
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            // pc still holds its reset value here
            ST_HALT: pc_target <= pc;
            ST_IF:   instr_q <= instr;
            ST_ID: begin
                raddr0 <= dec.rs1;
                raddr1 <= dec.rs2;
                waddr  <= dec.rd;
            end
            ST_EX: begin
                alu_op <= alu_sel(dec);
                alu_a  <= (dec.op inside {OPC_AUIPC, OPC_JAL}) ? pc : rdata0;
                alu_b  <= (dec.op inside {OPC_OP, OPC_BRANCH}) ? rdata1 : dec.imm;
            end
            ST_MM: begin
                mem_addr  <= alu_result;
                mem_wdata <= rdata1;
            end
            ST_WB: begin
                wdata     <= wb_sel(dec.op, alu_result, dec.imm, pc_next, mem_rdata);
                pc_target <= alu_result;
                pc_offset <= dec.imm;
            end
            default: ;
        endcase
    end

    assign mem_req = '{write: mem_write, addr: mem_addr, wdata: mem_wdata};

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {ST_HALT, ST_IF, ST_ID, ST_EX, ST_MM, ST_WB, ST_X1}
    );

endmodule

/* design/alu.sv */
module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    output rv_pkg::xlen_t   result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            default:  result = 32'd0;
        endcase
    end

endmodule

/* design/instr_decoder.sv */
module instr_decoder (
    input  rv_pkg::xlen_t    instr,
    output rv_pkg::decoded_t dec
);
    import rv_pkg::*;

    opcode_t op;
    xlen_t   imm_i;
    xlen_t   imm_s;
    xlen_t   imm_b;
    xlen_t   imm_u;
    xlen_t   imm_j;

    assign op = opcode_t'(instr[6:0]);

    // Immediate formats, all sign-extended from instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {
        {19{instr[31]}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };
    // U format lands pre-shifted
    assign imm_u = {instr[31:12], 12'd0};
    assign imm_j = {
        {11{instr[31]}},
        instr[31],
        instr[19:12],
        instr[20],
        instr[30:21],
        1'b0
    };

    always_comb begin
        dec.op       = op;
        dec.funct3   = instr[14:12];
        dec.funct7_5 = instr[30];
        dec.rs1      = instr[19:15];
        dec.rs2      = instr[24:20];
        dec.rd       = instr[11:7];
        case (op)
            OPC_OP_IMM,
            OPC_JALR,
            OPC_LOAD:   dec.imm = imm_i;
            OPC_STORE:  dec.imm = imm_s;
            OPC_BRANCH: dec.imm = imm_b;
            OPC_LUI,
            OPC_AUIPC:  dec.imm = imm_u;
            OPC_JAL:    dec.imm = imm_j;
            // R type has no immediate
            default:    dec.imm = 32'd0;
        endcase
    end

endmodule

/* design/reg_file.sv */
module reg_file (
    input  logic             clk,
    input  logic             wen,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::xlen_t    wdata,
    input  rv_pkg::reg_idx_t raddr0,
    input  rv_pkg::reg_idx_t raddr1,
    output rv_pkg::xlen_t    rdata0,
    output rv_pkg::xlen_t    rdata1
);
    import rv_pkg::*;

    // x1..x31 only, x0 is hardwired
    xlen_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];

    a_x0_zero: assert property (
        @(posedge clk) raddr0 == 5'd0 |-> rdata0 == 32'd0
    );

endmodule

/* design/program_counter.sv */
module program_counter #(
    parameter rv_pkg::xlen_t RESET_PC = 32'd2048
) (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::pc_mode_t mode,
    input  rv_pkg::xlen_t    offset,
    input  rv_pkg::xlen_t    target,
    output rv_pkg::xlen_t    pc,
    output rv_pkg::xlen_t    pc_next
);
    import rv_pkg::*;

    // Link value and sequential step
    assign pc_next = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            case (mode)
                PC_NEXT:   pc <= pc_next;
                PC_BRANCH: pc <= pc + offset;
                // JALR clears bit 0 of rs1 + imm
                PC_JUMP:   pc <= {target[31:1], 1'b0};
                default:   pc <= pc;
            endcase
        end
    end

    // Targets come from the controller, alignment is a program property
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    );

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [1:0] {
        PC_HOLD,
        PC_NEXT,
        PC_BRANCH,
        PC_JUMP
    } pc_mode_t;

    typedef enum logic [2:0] {
        ST_HALT,
        ST_IF,
        ST_ID,
        ST_EX,
        ST_MM,
        ST_WB,
        ST_X1
    } core_state_t;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        opcode_t    op;
        logic [2:0] funct3;
        logic       funct7_5;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        xlen_t      imm;
    } decoded_t;

    typedef struct packed {
        logic  write;
        xlen_t addr;
        xlen_t wdata;
    } mem_req_t;

endpackage
